// ==== design/region_cfg.svh ====
`ifndef REGION_CFG_SVH
`define REGION_CFG_SVH

// Width of one stored word
`define REGION_DATA_W 8

// Log2 of the depth of each store
`define REGION_ADDR_W 5

// Client channels sharing the region
`define REGION_NUM_CH 3

// Free FIFO slots at or below which almostfull rises
`define REGION_AFULL_MARGIN 4

`endif

// ==== design/region_data_pkg.sv ====
`include "region_cfg.svh"

package region_data_pkg;

    // ****************************************
    // Stored values
    // ****************************************

    // One word in either store
    typedef logic [`REGION_DATA_W-1:0] data_t;

    // RAM word address, also the width of the FIFO pointers
    typedef logic [`REGION_ADDR_W-1:0] addr_t;

    // Extra bit so the fill level can reach the full depth
    typedef logic [`REGION_ADDR_W:0] count_t;

endpackage

// ==== design/region_access_pkg.sv ====
`include "region_cfg.svh"

package region_access_pkg;

    // ****************************************
    // Client access
    // ****************************************

    // Store a read request is aimed at
    typedef enum logic [1:0] {
        TGT_NONE = 2'd0,
        TGT_RAM  = 2'd1,
        TGT_FIFO = 2'd2
    } target_e;

    // Write mask, one bit per store
    typedef logic [1:0] wmask_t;

    localparam int unsigned WMASK_RAM  = 0;
    localparam int unsigned WMASK_FIFO = 1;

    localparam int unsigned CHAN_W = (`REGION_NUM_CH > 1) ? $clog2(`REGION_NUM_CH) : 1;

    typedef logic [CHAN_W-1:0] chan_t;

    // Lowest requesting channel wins
    function automatic chan_t first_req(input logic [`REGION_NUM_CH-1:0] req);
        chan_t idx;
        idx = '0;
        for (int i = `REGION_NUM_CH - 1; i >= 0; i--) begin
            if (req[i]) begin
                idx = chan_t'(i);
            end
        end
        return idx;
    endfunction

endpackage

// ==== design/store_if.sv ====
`timescale 1ns/1ns

interface store_if;

    import region_data_pkg::*;

    // Read side
    logic  re;
    addr_t raddr;
    logic  rvalid;
    data_t rdata;

    // Write side
    logic  we;
    addr_t waddr;
    data_t wdata;

    // Only the FIFO has real flags
    logic  empty;
    logic  almostfull;

    modport rd_master (
        output re,
        output raddr,
        input  rvalid,
        input  rdata,
        input  empty,
        input  almostfull
    );

    modport wr_master (
        output we,
        output waddr,
        output wdata
    );

    modport store (
        input  re,
        input  raddr,
        output rvalid,
        output rdata,
        input  we,
        input  waddr,
        input  wdata,
        output empty,
        output almostfull
    );

endinterface

// ==== design/region_ram.sv ====
`timescale 1ns/1ns

`include "region_cfg.svh"

module region_ram (
    input logic    clk,
    store_if.store bus
);

    import region_data_pkg::*;

    localparam int unsigned DEPTH = 1 << `REGION_ADDR_W;

    data_t mem [DEPTH];

    // Registered write
    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[bus.waddr] <= bus.wdata;
        end
    end

    // Registered read, one cycle of latency
    always_ff @(posedge clk) begin
        bus.rvalid <= bus.re;
        if (bus.re) begin
            bus.rdata <= mem[bus.raddr];
        end
    end

endmodule

// ==== design/region_fifo.sv ====
`timescale 1ns/1ns

`include "region_cfg.svh"

module region_fifo (
    input logic    clk,
    input logic    rst_n,
    store_if.store bus
);

    import region_data_pkg::*;

    localparam int unsigned DEPTH = 1 << `REGION_ADDR_W;
    localparam count_t FULL_LEVEL  = count_t'(DEPTH);
    localparam count_t AFULL_LEVEL = count_t'(DEPTH - `REGION_AFULL_MARGIN);

    data_t  mem [DEPTH];
    addr_t  wr_ptr;
    addr_t  rd_ptr;
    count_t count;
    count_t count_nxt;
    logic   do_wr;
    logic   do_rd;

    // Write into a full FIFO is dropped, read of an empty one too
    assign do_wr = bus.we && (count != FULL_LEVEL);
    assign do_rd = bus.re && (count != '0);

    always_comb begin
        count_nxt = count;
        if (do_wr && !do_rd) begin
            count_nxt = count + 1'b1;
        end else if (do_rd && !do_wr) begin
            count_nxt = count - 1'b1;
        end
    end

    // ****************************************
    // Pointers, level and flags
    // ****************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            bus.rvalid     <= 1'b0;
            bus.empty      <= 1'b1;
            bus.almostfull <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count          <= count_nxt;
            bus.rvalid     <= do_rd;
            bus.empty      <= (count_nxt == '0);
            bus.almostfull <= (count_nxt >= AFULL_LEVEL);
        end
    end

    // ****************************************
    // Storage
    // ****************************************
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= bus.wdata;
        end
        if (do_rd) begin
            bus.rdata <= mem[rd_ptr];
        end
    end

endmodule

// ==== design/read_arbiter.sv ====
`timescale 1ns/1ns

`include "region_cfg.svh"

module read_arbiter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        re     [`REGION_NUM_CH],
    input  region_access_pkg::target_e  rsel   [`REGION_NUM_CH],
    input  region_data_pkg::addr_t      raddr  [`REGION_NUM_CH],
    output logic                        rvalid [`REGION_NUM_CH],
    output region_data_pkg::data_t      rdata  [`REGION_NUM_CH],
    output logic                        empty,
    output logic                        almostfull,
    store_if.rd_master                  ram_bus,
    store_if.rd_master                  fifo_bus
);

    import region_access_pkg::*;

    logic [`REGION_NUM_CH-1:0] ram_req;
    logic [`REGION_NUM_CH-1:0] fifo_req;
    chan_t                     ram_sel;
    chan_t                     fifo_sel;
    logic                      re_q  [`REGION_NUM_CH];
    target_e                   tgt_q [`REGION_NUM_CH];

    // ****************************************
    // Request side
    // ****************************************
    always_comb begin
        for (int c = 0; c < `REGION_NUM_CH; c++) begin
            ram_req[c]  = re[c] && (rsel[c] == TGT_RAM);
            fifo_req[c] = re[c] && (rsel[c] == TGT_FIFO);
        end
    end

    assign ram_sel  = first_req(ram_req);
    assign fifo_sel = first_req(fifo_req);

    assign ram_bus.re     = |ram_req;
    assign ram_bus.raddr  = raddr[ram_sel];
    assign fifo_bus.re    = |fifo_req;
    assign fifo_bus.raddr = raddr[fifo_sel];

    // Target tag follows the store latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < `REGION_NUM_CH; c++) begin
                re_q[c]  <= 1'b0;
                tgt_q[c] <= TGT_NONE;
            end
        end else begin
            for (int c = 0; c < `REGION_NUM_CH; c++) begin
                re_q[c]  <= re[c];
                tgt_q[c] <= rsel[c];
            end
        end
    end

    // ****************************************
    // Return side
    // ****************************************
    always_comb begin
        for (int c = 0; c < `REGION_NUM_CH; c++) begin
            rvalid[c] = re_q[c] && ((tgt_q[c] == TGT_RAM && ram_bus.rvalid) ||
                                    (tgt_q[c] == TGT_FIFO && fifo_bus.rvalid));
            rdata[c]  = (tgt_q[c] == TGT_RAM) ? ram_bus.rdata : fifo_bus.rdata;
        end
    end

    // Flags shared by all channels
    assign empty      = fifo_bus.empty;
    assign almostfull = fifo_bus.almostfull;

endmodule

// ==== design/write_arbiter.sv ====
`timescale 1ns/1ns

`include "region_cfg.svh"

module write_arbiter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we    [`REGION_NUM_CH],
    input  region_access_pkg::wmask_t   wsel  [`REGION_NUM_CH],
    input  region_data_pkg::addr_t      waddr [`REGION_NUM_CH],
    input  region_data_pkg::data_t      wdata [`REGION_NUM_CH],
    store_if.wr_master                  ram_bus,
    store_if.wr_master                  fifo_bus
);

    import region_access_pkg::*;

    logic [`REGION_NUM_CH-1:0] ram_req;
    logic [`REGION_NUM_CH-1:0] fifo_req;
    chan_t                     ram_sel;
    chan_t                     fifo_sel;

    // A write may select both stores at once
    always_comb begin
        for (int c = 0; c < `REGION_NUM_CH; c++) begin
            ram_req[c]  = we[c] && wsel[c][WMASK_RAM];
            fifo_req[c] = we[c] && wsel[c][WMASK_FIFO];
        end
    end

    assign ram_sel  = first_req(ram_req);
    assign fifo_sel = first_req(fifo_req);

    // Enables last one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ram_bus.we  <= 1'b0;
            fifo_bus.we <= 1'b0;
        end else begin
            ram_bus.we  <= |ram_req;
            fifo_bus.we <= |fifo_req;
        end
    end

    // Winning payload per store
    always_ff @(posedge clk) begin
        ram_bus.waddr  <= waddr[ram_sel];
        ram_bus.wdata  <= wdata[ram_sel];
        fifo_bus.waddr <= waddr[fifo_sel];
        fifo_bus.wdata <= wdata[fifo_sel];
    end

endmodule

// ==== design/region.sv ====
`timescale 1ns/1ns

`include "region_cfg.svh"

module region (
    input  logic                        clk,
    input  logic                        rst_n,

    // Read requests
    input  logic                        re     [`REGION_NUM_CH],
    input  region_access_pkg::target_e  rsel   [`REGION_NUM_CH],
    input  region_data_pkg::addr_t      raddr  [`REGION_NUM_CH],

    // Write requests
    input  logic                        we     [`REGION_NUM_CH],
    input  region_access_pkg::wmask_t   wsel   [`REGION_NUM_CH],
    input  region_data_pkg::addr_t      waddr  [`REGION_NUM_CH],
    input  region_data_pkg::data_t      wdata  [`REGION_NUM_CH],

    // Returns
    output logic                        rvalid [`REGION_NUM_CH],
    output region_data_pkg::data_t      rdata  [`REGION_NUM_CH],

    // Shared FIFO flags
    output logic                        empty,
    output logic                        almostfull
);

    store_if ram_bus ();
    store_if fifo_bus ();

    // ****************************************
    // Arbiters
    // ****************************************
    read_arbiter i_read_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .re         (re),
        .rsel       (rsel),
        .raddr      (raddr),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .empty      (empty),
        .almostfull (almostfull),
        .ram_bus    (ram_bus.rd_master),
        .fifo_bus   (fifo_bus.rd_master)
    );

    write_arbiter i_write_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (we),
        .wsel     (wsel),
        .waddr    (waddr),
        .wdata    (wdata),
        .ram_bus  (ram_bus.wr_master),
        .fifo_bus (fifo_bus.wr_master)
    );

    // ****************************************
    // Stores
    // ****************************************
    region_ram i_region_ram (
        .clk (clk),
        .bus (ram_bus.store)
    );

    region_fifo i_region_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (fifo_bus.store)
    );

endmodule

// ==== bench/region_asserts.sv ====
`timescale 1ns/1ns

`include "region_cfg.svh"

module region_asserts #(
    parameter string SIDE        = "read",
    parameter bit    CHECK_FLAGS = 1'b1
) (
    input logic                      clk,
    input logic                      rst_n,
    input logic [`REGION_NUM_CH-1:0] ram_req,
    input logic [`REGION_NUM_CH-1:0] fifo_req,
    input logic                      empty,
    input logic                      almostfull
);

    // Clients never share a store in one cycle
    ram_excl: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ram_req))
        else $error("Two channels sent %s requests to the RAM in one cycle", SIDE);

    fifo_excl: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(fifo_req))
        else $error("Two channels sent %s requests to the FIFO in one cycle", SIDE);

    // Only the read side carries the FIFO flags
    if (CHECK_FLAGS) begin : g_flags
        flags_excl: assert property (@(posedge clk) disable iff (!rst_n) !(empty && almostfull))
            else $error("FIFO reports empty and almostfull together");
    end

endmodule

// ****************************************
// Attachments
// ****************************************
bind read_arbiter region_asserts #(.SIDE("read"), .CHECK_FLAGS(1'b1)) i_read_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .ram_req    (ram_req),
    .fifo_req   (fifo_req),
    .empty      (empty),
    .almostfull (almostfull)
);

bind write_arbiter region_asserts #(.SIDE("write"), .CHECK_FLAGS(1'b0)) i_write_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .ram_req    (ram_req),
    .fifo_req   (fifo_req),
    .empty      (1'b0),
    .almostfull (1'b0)
);

// ==== bench/region_tb.sv ====
`timescale 1ns/1ns

`include "region_cfg.svh"

module region_tb;

    import region_data_pkg::*;
    import region_access_pkg::*;

    localparam int NUM_CH  = `REGION_NUM_CH;
    localparam int DEPTH   = 1 << `REGION_ADDR_W;
    localparam int TIMEOUT = 20;

    localparam int OP_IDLE = 0;
    localparam int OP_WR   = 1;
    localparam int OP_RD   = 2;

    // Write masks
    localparam logic [1:0] WR_RAM  = 2'b01;
    localparam logic [1:0] WR_FIFO = 2'b10;
    localparam logic [1:0] WR_BOTH = 2'b11;

    // One table row; par joins a row with the next one in the same cycle
    typedef struct {
        int         ch;
        int         op;
        logic [1:0] sel;
        addr_t      addr;
        data_t      data;
        bit         expv;
        bit         par;
    } row_t;

    logic    clk;
    logic    rst_n;
    logic    re     [NUM_CH];
    target_e rsel   [NUM_CH];
    addr_t   raddr  [NUM_CH];
    logic    we     [NUM_CH];
    wmask_t  wsel   [NUM_CH];
    addr_t   waddr  [NUM_CH];
    data_t   wdata  [NUM_CH];
    logic    rvalid [NUM_CH];
    data_t   rdata  [NUM_CH];
    logic    empty;
    logic    almostfull;

    row_t    rows [$];
    data_t   model_ram [DEPTH];
    data_t   model_fifo [$];
    integer  seed;
    int      errors;
    int      checks;
    int      idx;

    region i_region (
        .clk        (clk),
        .rst_n      (rst_n),
        .re         (re),
        .rsel       (rsel),
        .raddr      (raddr),
        .we         (we),
        .wsel       (wsel),
        .waddr      (waddr),
        .wdata      (wdata),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .empty      (empty),
        .almostfull (almostfull)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ****************************************
    // Helpers
    // ****************************************
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic clear_requests();
        for (int c = 0; c < NUM_CH; c++) begin
            re[c]    = 1'b0;
            rsel[c]  = TGT_NONE;
            raddr[c] = '0;
            we[c]    = 1'b0;
            wsel[c]  = '0;
            waddr[c] = '0;
            wdata[c] = '0;
        end
    endtask

    task automatic add_row(input int ch, input int op, input logic [1:0] sel, input int addr,
                           input int data, input bit expv, input bit par);
        row_t r;
        r.ch   = ch;
        r.op   = op;
        r.sel  = sel;
        r.addr = addr_t'(addr);
        r.data = data_t'(data);
        r.expv = expv;
        r.par  = par;
        rows.push_back(r);
    endtask

    // Flags predicted from the model FIFO level
    task automatic check_flags();
        int level;
        level = model_fifo.size();
        compare("empty", empty, level == 0);
        compare("almostfull", almostfull, (DEPTH - level) <= `REGION_AFULL_MARGIN);
    endtask

    // ****************************************
    // Stimulus table
    // ****************************************
    task automatic build_table();
        add_row(0, OP_IDLE, 2'b00, 0, 0, 0, 0);
        // RAM write on one channel, read on another
        add_row(0, OP_WR, WR_RAM, 'h05, 'ha5, 0, 0);
        add_row(2, OP_RD, TGT_RAM, 'h05, 0, 1, 0);
        // FIFO order across writers
        add_row(0, OP_WR, WR_FIFO, 0, 'h11, 0, 0);
        add_row(1, OP_WR, WR_FIFO, 0, 'h22, 0, 0);
        add_row(2, OP_WR, WR_FIFO, 0, 'h33, 0, 0);
        add_row(1, OP_RD, TGT_FIFO, 0, 0, 1, 0);
        add_row(2, OP_RD, TGT_FIFO, 0, 0, 1, 0);
        add_row(0, OP_RD, TGT_FIFO, 0, 0, 1, 0);
        add_row(1, OP_RD, TGT_FIFO, 0, 0, 0, 0);
        // Same word into both stores
        add_row(1, OP_WR, WR_BOTH, 'h0a, 'h5c, 0, 0);
        add_row(0, OP_RD, TGT_RAM, 'h0a, 0, 1, 0);
        add_row(2, OP_RD, TGT_FIFO, 0, 0, 1, 0);
        // Parallel reads on both stores
        add_row(2, OP_WR, WR_RAM, 'h1f, 'hc3, 0, 0);
        add_row(1, OP_WR, WR_FIFO, 0, 'h3c, 0, 0);
        add_row(0, OP_RD, TGT_RAM, 'h1f, 0, 1, 1);
        add_row(1, OP_RD, TGT_FIFO, 0, 0, 1, 0);
        add_row(1, OP_RD, TGT_RAM, 'h05, 0, 1, 0);
        // Fill up to the almostfull level, then drain one
        for (int i = 0; i < DEPTH - `REGION_AFULL_MARGIN; i++) begin
            add_row(i % NUM_CH, OP_WR, WR_FIFO, 0, $random(seed), 0, 0);
        end
        add_row(2, OP_RD, TGT_FIFO, 0, 0, 1, 0);
        add_row(2, OP_IDLE, 2'b00, 0, 0, 0, 0);
    endtask

    task automatic drive_row(input row_t r);
        if (r.op == OP_WR) begin
            we[r.ch]    = 1'b1;
            wsel[r.ch]  = wmask_t'(r.sel);
            waddr[r.ch] = r.addr;
            wdata[r.ch] = r.data;
            if (r.sel[0]) begin
                model_ram[r.addr] = r.data;
            end
            if (r.sel[1] && model_fifo.size() < DEPTH) begin
                model_fifo.push_back(r.data);
            end
        end else if (r.op == OP_RD) begin
            re[r.ch]    = 1'b1;
            rsel[r.ch]  = target_e'(r.sel);
            raddr[r.ch] = r.addr;
        end
    endtask

    task automatic run_group(input int first, input int n);
        bit    want [NUM_CH];
        data_t exp_word [NUM_CH];
        bit    any_read;
        int    lead;
        int    waited;
        any_read = 1'b0;
        lead     = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            want[c]     = 1'b0;
            exp_word[c] = '0;
        end
        for (int k = first; k < first + n; k++) begin
            drive_row(rows[k]);
            if (rows[k].op == OP_RD) begin
                if (rows[k].sel == TGT_RAM) begin
                    exp_word[rows[k].ch] = model_ram[rows[k].addr];
                end else if (model_fifo.size() > 0) begin
                    exp_word[rows[k].ch] = model_fifo.pop_front();
                end
                if (rows[k].expv) begin
                    want[rows[k].ch] = 1'b1;
                    if (!any_read) begin
                        lead = rows[k].ch;
                    end
                    any_read = 1'b1;
                end
            end
        end
        tick();
        clear_requests();
        if (any_read) begin
            waited = 0;
            while (!rvalid[lead] && waited < TIMEOUT) begin
                tick();
                waited++;
            end
            if (!rvalid[lead]) begin
                errors++;
                $display("Timeout: no read return on channel %0d", lead);
            end
        end
        // Returns only where asked, for one cycle
        for (int c = 0; c < NUM_CH; c++) begin
            compare($sformatf("rvalid[%0d]", c), rvalid[c], want[c]);
            if (want[c]) begin
                compare($sformatf("rdata[%0d]", c), rdata[c], exp_word[c]);
            end
        end
        tick();
        for (int c = 0; c < NUM_CH; c++) begin
            compare($sformatf("rvalid[%0d]", c), rvalid[c], 1'b0);
        end
        check_flags();
    endtask

    // ****************************************
    // Main sequence
    // ****************************************
    initial begin
        seed   = 60;
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        clear_requests();
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        compare("empty", empty, 1'b1);
        compare("almostfull", almostfull, 1'b0);
        for (int c = 0; c < NUM_CH; c++) begin
            compare($sformatf("rvalid[%0d]", c), rvalid[c], 1'b0);
        end
        idx = 0;
        while (idx < rows.size()) begin
            if (rows[idx].par) begin
                run_group(idx, 2);
                idx += 2;
            end else begin
                run_group(idx, 1);
                idx += 1;
            end
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+design
design/region_data_pkg.sv
design/region_access_pkg.sv
design/store_if.sv
design/region_ram.sv
design/region_fifo.sv
design/read_arbiter.sv
design/write_arbiter.sv
design/region.sv
bench/region_asserts.sv
bench/region_tb.sv

// ==== Bender.yml ====
package:
  name: region

sources:
  - include_dirs:
      - design
    files:
      - design/region_data_pkg.sv
      - design/region_access_pkg.sv
      - design/store_if.sv
      - design/region_ram.sv
      - design/region_fifo.sv
      - design/read_arbiter.sv
      - design/write_arbiter.sv
      - design/region.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/region_asserts.sv
      - bench/region_tb.sv
